// ==== branch_decode.sv ====
`default_nettype none

module branch_decode
    import mips_isa_pkg::*, fetch_if_pkg::*;
#(
    parameter int DQ_DEPTH    = 4,
    parameter int OUT_CREDITS = 2
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        fw_valid,
    input  fetch_word_t fw,
    input  logic        out_credit,
    output logic        fw_credit,
    output logic        redirect_valid,
    output redirect_t   redirect,
    output logic        out_valid,
    output decoded_t    out
);

    localparam int PW = $clog2(DQ_DEPTH);
    localparam int QW = $clog2(DQ_DEPTH + 1);
    localparam int CW = $clog2(OUT_CREDITS + 1);

    typedef enum logic {
        st_seq,     // next item follows sequentially
        st_slot     // next item is a delay slot
    } flow_state_t;

    fetch_word_t   q_mem [DQ_DEPTH];
    logic [PW-1:0] rd_ptr;
    logic [PW-1:0] wr_ptr;
    logic [QW-1:0] q_count;
    logic [CW-1:0] out_cnt;
    flow_state_t   state;
    logic [31:0]   expect_pc;

    fetch_word_t   head;
    logic          head_valid;
    logic          on_path;
    logic          emit;
    logic          pop;
    logic          rs_eq_rt;
    logic          taken;
    logic [5:0]    raw_op;
    opcode_t       op;
    logic [31:0]   slot_pc;
    logic [31:0]   jump_target;
    logic [31:0]   branch_target;
    logic [31:0]   next_target;

    function automatic logic [PW-1:0] ptr_inc(input logic [PW-1:0] p);
        logic [PW-1:0] n;
        if (p == PW'(DQ_DEPTH - 1)) begin
            n = '0;
        end else begin
            n = p + 1'b1;
        end
        return n;
    endfunction

    always_comb begin
        head       = q_mem[rd_ptr];
        head_valid = q_count != '0;
        on_path    = head.pc == expect_pc;               // else a wrong-path word
        emit       = head_valid && on_path && out_cnt != '0;
        pop        = emit || (head_valid && !on_path);

        raw_op = head.word[OPC_HI:OPC_LO];
        case (raw_op)
            RAW_J:   op = op_j;
            RAW_JAL: op = op_jal;
            RAW_BEQ: op = op_beq;
            RAW_BNE: op = op_bne;
            default: op = op_other;
        endcase

        rs_eq_rt      = head.word[RS_HI:RS_LO] == head.word[RT_HI:RT_LO];
        slot_pc       = head.pc + 32'd4;
        jump_target   = {slot_pc[31:28], head.word[IDX_HI:IDX_LO], 2'b00};
        branch_target = slot_pc + {{14{head.word[OFF_HI]}}, head.word[OFF_HI:OFF_LO], 2'b00};
        next_target   = (op == op_beq) ? branch_target : jump_target;

        // a control word sitting in a delay slot is not followed
        taken = (state == st_seq) &&
                (op == op_j || op == op_jal || (op == op_beq && rs_eq_rt));
    end

    assign out_valid = emit;
    assign out       = '{pc: head.pc, word: head.word, op: op, in_delay_slot: state == st_slot};

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr         <= '0;
            wr_ptr         <= '0;
            q_count        <= '0;
            out_cnt        <= CW'(OUT_CREDITS);
            state          <= st_seq;
            expect_pc      <= BOOT_VECTOR;
            fw_credit      <= 1'b0;
            redirect_valid <= 1'b0;
        end else begin
            if (fw_valid) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            q_count        <= q_count + QW'(fw_valid) - QW'(pop);
            out_cnt        <= out_cnt + CW'(out_credit) - CW'(emit);
            fw_credit      <= pop;                       // one credit per entry freed
            redirect_valid <= emit && taken;
            if (emit) begin
                if (state == st_slot) begin
                    expect_pc <= redirect.target;         // slot done, go to target
                    state     <= st_seq;
                end else if (taken) begin
                    expect_pc <= slot_pc;
                    state     <= st_slot;
                end else begin
                    expect_pc <= slot_pc;
                end
            end
        end
    end

    // queue storage and redirect payload
    always_ff @(posedge clk) begin
        if (fw_valid) begin
            q_mem[wr_ptr] <= fw;
        end
        if (emit && taken) begin
            redirect <= '{slot_pc: slot_pc, target: next_target};
        end
    end

endmodule

`default_nettype wire

// ==== fetch_cases.txt ====
// columns: tag address value. tag 1 is a memory word (address, word),
// tag 2 an expected output (pc, op nibble then delay slot flag), tag 0 ends
1 bfc00008 0bf00010
1 bfc00040 0ff00020
1 bfc00080 14630005
1 bfc00088 1042000d
1 bfc000c0 1021fff7
1 bfc000a0 10220003
2 bfc00000 00
2 bfc00004 00
2 bfc00008 10
2 bfc0000c 01
2 bfc00040 20
2 bfc00044 01
2 bfc00080 40
2 bfc00084 00
2 bfc00088 30
2 bfc0008c 01
2 bfc000c0 30
2 bfc000c4 01
2 bfc000a0 30
2 bfc000a4 00
2 bfc000a8 00
0 0 0

// ==== fetch_front_end.sv ====
`default_nettype none

module fetch_front_end
    import fetch_if_pkg::*;
#(
    parameter int DQ_DEPTH    = 4,
    parameter int OUT_CREDITS = 2
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        mem_waitrequest,
    input  logic [31:0] mem_readdata,
    input  logic        out_credit,
    output logic        mem_read,
    output logic [31:0] mem_addr,
    output logic        out_valid,
    output decoded_t    out
);

    logic [31:0] pc;
    logic        accept_pulse;
    logic        fw_valid;
    fetch_word_t fw;
    logic        fw_credit;
    logic        redirect_valid;
    redirect_t   redirect;

    pc_unit pc_unit0 (
        .clk            (clk),
        .reset          (reset),
        .accept_pulse   (accept_pulse),
        .redirect_valid (redirect_valid),
        .redirect       (redirect),
        .pc             (pc)
    );

    fetch_stage #(
        .DQ_DEPTH (DQ_DEPTH)
    ) fetch_stage0 (
        .clk             (clk),
        .reset           (reset),
        .pc              (pc),
        .mem_waitrequest (mem_waitrequest),
        .mem_readdata    (mem_readdata),
        .fw_credit       (fw_credit),
        .mem_read        (mem_read),
        .mem_addr        (mem_addr),
        .accept_pulse    (accept_pulse),
        .fw_valid        (fw_valid),
        .fw              (fw)
    );

    branch_decode #(
        .DQ_DEPTH    (DQ_DEPTH),
        .OUT_CREDITS (OUT_CREDITS)
    ) branch_decode0 (
        .clk            (clk),
        .reset          (reset),
        .fw_valid       (fw_valid),
        .fw             (fw),
        .out_credit     (out_credit),
        .fw_credit      (fw_credit),
        .redirect_valid (redirect_valid),
        .redirect       (redirect),
        .out_valid      (out_valid),
        .out            (out)
    );

endmodule

`default_nettype wire

// ==== fetch_front_end_assert.sv ====
`default_nettype none

module protocol_checks #(
    parameter int OUT_CREDITS = 2
) (
    input logic        clk,
    input logic        reset,
    input logic        mem_read,
    input logic        mem_waitrequest,
    input logic [31:0] mem_addr,
    input logic        out_valid,
    input logic        out_credit
);

    timeunit 1ns;
    timeprecision 1ps;

    int credits;        // output credits the DUT may still spend
    int failures = 0;   // failed assertions, read by the testbench

    always_ff @(posedge clk) begin
        if (reset) begin
            credits <= OUT_CREDITS;
        end else begin
            credits <= credits + int'(out_credit) - int'(out_valid);
        end
    end

    addr_held: assert property (@(posedge clk) disable iff (reset)
        mem_read && mem_waitrequest |=> mem_read && $stable(mem_addr))
        else begin
            $error("read request changed while waitrequest was high");
            failures++;
        end

    addr_aligned: assert property (@(posedge clk) disable iff (reset)
        mem_read |-> mem_addr[1:0] == 2'b00)
        else begin
            $error("mem_addr is not word aligned");
            failures++;
        end

    credit_bound: assert property (@(posedge clk) disable iff (reset)
        out_valid |-> credits > 0)
        else begin
            $error("out_valid raised without an output credit");
            failures++;
        end

endmodule

bind fetch_front_end protocol_checks #(
    .OUT_CREDITS (OUT_CREDITS)
) checks0 (
    .clk             (clk),
    .reset           (reset),
    .mem_read        (mem_read),
    .mem_waitrequest (mem_waitrequest),
    .mem_addr        (mem_addr),
    .out_valid       (out_valid),
    .out_credit      (out_credit)
);

`default_nettype wire

// ==== fetch_front_end_tb.sv ====
`default_nettype none

module fetch_front_end_tb
    import mips_isa_pkg::*, fetch_if_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int DQ_DEPTH    = 4;
    localparam int OUT_CREDITS = 2;
    localparam int MAX_WAIT    = 3000;   // cycles allowed per wait

    logic        clk             = 1'b0;
    logic        reset           = 1'b1;
    logic        mem_waitrequest = 1'b1;
    logic [31:0] mem_readdata    = '0;
    logic        out_credit      = 1'b0;
    logic        mem_read;
    logic [31:0] mem_addr;
    logic        out_valid;
    decoded_t    out;

    logic [31:0] cases_mem [0:95];
    logic [31:0] image [logic [31:0]];   // holds control words only
    logic [31:0] exp_pc [$];
    logic [7:0]  exp_code [$];           // op in the high nibble and delay slot flag in bit 0
    logic [15:0] lfsr      = 16'd63;
    logic        hold      = 1'b0;       // consumer keeps its credits
    int          rcv_count = 0;
    int          owed      = 0;
    int          gap       = 0;
    int          errors    = 0;
    int          timeouts  = 0;

    fetch_front_end #(
        .DQ_DEPTH    (DQ_DEPTH),
        .OUT_CREDITS (OUT_CREDITS)
    ) dut0 (
        .clk             (clk),
        .reset           (reset),
        .mem_waitrequest (mem_waitrequest),
        .mem_readdata    (mem_readdata),
        .out_credit      (out_credit),
        .mem_read        (mem_read),
        .mem_addr        (mem_addr),
        .out_valid       (out_valid),
        .out             (out)
    );

    always #50 clk = ~clk;

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        if (image.exists(addr)) begin
            return image[addr];
        end
        return addr ^ 32'h5A5A_A5A5;     // fill word has opcode 0x39 near the boot vector
    endfunction

    task automatic check_value(input string name, input int idx, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp)
        else begin
            $display("ERROR %s of item %0d: expected %h, actual %h", name, idx, exp, act);
            errors++;
        end
    endtask

    task automatic load_cases();
        int i;
        i = 0;
        $readmemh("fetch_cases.txt", cases_mem);
        while (i + 2 < 96 && (cases_mem[i] == 32'd1 || cases_mem[i] == 32'd2)) begin
            if (cases_mem[i] == 32'd1) begin
                image[cases_mem[i + 1]] = cases_mem[i + 2];
            end else begin
                exp_pc.push_back(cases_mem[i + 1]);
                exp_code.push_back(cases_mem[i + 2][7:0]);
            end
            i += 3;
        end
        assert (exp_pc.size() > 0)
        else begin
            $display("no expected items could be read from fetch_cases.txt");
            errors++;
        end
    endtask

    task automatic wait_items(input int n);
        int t;
        t = 0;
        while (rcv_count < n && t < MAX_WAIT) begin
            @(posedge clk);
            t++;
        end
        assert (rcv_count >= n)
        else begin
            $display("timed out waiting for output item %0d, got %0d", n, rcv_count);
            timeouts++;
        end
    endtask

    task automatic wait_fetch_idle(input int cycles);
        int t;
        int low;
        t = 0;
        low = 0;
        while (low < cycles && t < MAX_WAIT) begin
            @(posedge clk);
            low = mem_read ? 0 : low + 1;
            t++;
        end
        assert (low >= cycles)
        else begin
            $display("mem_read never stayed low while the consumer held its credits");
            timeouts++;
        end
    endtask

    // memory slave and consumer credit return
    always @(posedge clk) begin : drive
        logic [1:0] r;
        if (mem_read && mem_waitrequest) begin
            mem_readdata    <= mem_word(mem_addr);
            mem_waitrequest <= lfsr[0];          // random stall
            lfsr             = lfsr_next(lfsr);
        end else begin
            mem_readdata    <= 32'hx;
            mem_waitrequest <= 1'b1;             // every read starts stalled
        end
        if (reset) begin
            owed = 0;
            gap  = 0;
        end else if (out_valid) begin
            owed = owed + 1;
        end
        out_credit <= 1'b0;
        if (gap != 0) begin
            gap = gap - 1;
        end else if (owed != 0 && !hold) begin
            out_credit <= 1'b1;
            owed = owed - 1;
            r[0] = lfsr[0];
            lfsr = lfsr_next(lfsr);
            r[1] = lfsr[0];
            lfsr = lfsr_next(lfsr);
            gap  = int'(r);                      // 0 to 3 idle cycles
        end
    end

    always @(posedge clk) begin
        if (!reset && out_valid) begin
            if (rcv_count < exp_pc.size()) begin
                check_value("pc", rcv_count, exp_pc[rcv_count], out.pc);
                check_value("word", rcv_count, mem_word(exp_pc[rcv_count]), out.word);
                check_value("op", rcv_count, 32'(exp_code[rcv_count][7:4]), 32'(out.op));
                check_value("in_delay_slot", rcv_count, 32'(exp_code[rcv_count][0]),
                            32'(out.in_delay_slot));
            end
            rcv_count <= rcv_count + 1;
        end
    end

    initial begin
        load_cases();
        @(posedge clk);
        @(posedge clk);
        assert (mem_read === 1'b0 && out_valid === 1'b0)
        else begin
            $display("mem_read or out_valid was not low during reset");
            errors++;
        end
        reset <= 1'b0;
        wait_items(6);
        hold <= 1'b1;                            // starve the consumer side
        wait_fetch_idle(20);
        hold <= 1'b0;
        wait_items(exp_pc.size());
        $display("items %0d of %0d, check errors %0d, timeouts %0d, assertion failures %0d",
                 rcv_count, exp_pc.size(), errors, timeouts, dut0.checks0.failures);
        if (errors == 0 && timeouts == 0 && dut0.checks0.failures == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== fetch_if_pkg.sv ====
`default_nettype none

package fetch_if_pkg;

    // fetch stage to decode stage
    typedef struct packed {
        logic [31:0]               pc;
        mips_isa_pkg::instr_word_t word;
    } fetch_word_t;

    // decode stage to PC stage
    typedef struct packed {
        logic [31:0] slot_pc;   // address of the delay slot
        logic [31:0] target;    // where flow goes after the slot
    } redirect_t;

    // decode stage to consumer
    typedef struct packed {
        logic [31:0]               pc;
        mips_isa_pkg::instr_word_t word;
        mips_isa_pkg::opcode_t     op;
        logic                      in_delay_slot;
    } decoded_t;

endpackage

`default_nettype wire

// ==== fetch_stage.sv ====
`default_nettype none

module fetch_stage
    import fetch_if_pkg::*;
#(
    parameter int DQ_DEPTH = 4
) (
    input  logic        clk,
    input  logic        reset,
    input  logic [31:0] pc,
    input  logic        mem_waitrequest,
    input  logic [31:0] mem_readdata,
    input  logic        fw_credit,
    output logic        mem_read,
    output logic [31:0] mem_addr,
    output logic        accept_pulse,
    output logic        fw_valid,
    output fetch_word_t fw
);

    localparam int CW = $clog2(DQ_DEPTH + 1);

    logic [CW-1:0] credit_q;    // free decode queue slots
    logic          read_q;
    logic [31:0]   addr_q;
    logic          accept;

    // read completes when the memory stops waiting
    assign accept       = read_q && !mem_waitrequest;
    assign accept_pulse = accept && addr_q == pc;   // a read launched before a redirect keeps pc
    assign mem_read     = read_q;
    assign mem_addr     = addr_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            credit_q <= CW'(DQ_DEPTH);
            read_q   <= 1'b0;
            fw_valid <= 1'b0;
        end else begin
            credit_q <= credit_q - CW'(accept) + CW'(fw_credit);
            fw_valid <= accept;
            if (accept) begin
                read_q <= 1'b0;     // pc steps this edge and relaunch follows
            end else if (!read_q && credit_q != '0) begin
                read_q <= 1'b1;
            end
        end
    end

    // address latched at launch so it holds through waitrequest
    always_ff @(posedge clk) begin
        if (!read_q) begin
            addr_q <= pc;
        end
    end

    // captured word for decode
    always_ff @(posedge clk) begin
        if (accept) begin
            fw.pc   <= addr_q;
            fw.word <= mem_readdata;
        end
    end

endmodule

`default_nettype wire

// ==== mips_isa_pkg.sv ====
`default_nettype none

package mips_isa_pkg;

    // raw 32-bit instruction as read from memory
    typedef logic [31:0] instr_word_t;

    // classes the front end cares about, everything else is op_other
    typedef enum logic [2:0] {
        op_other,
        op_j,
        op_jal,
        op_beq,
        op_bne
    } opcode_t;

    localparam logic [31:0] BOOT_VECTOR = 32'hBFC0_0000;   // first fetch after reset

    // field positions
    localparam int OPC_HI = 31;
    localparam int OPC_LO = 26;
    localparam int RS_HI  = 25;
    localparam int RS_LO  = 21;
    localparam int RT_HI  = 20;
    localparam int RT_LO  = 16;
    localparam int OFF_HI = 15;     // 16-bit branch offset
    localparam int OFF_LO = 0;
    localparam int IDX_HI = 25;     // 26-bit jump index
    localparam int IDX_LO = 0;

    // primary opcode encodings
    localparam logic [5:0] RAW_J   = 6'b000010;
    localparam logic [5:0] RAW_JAL = 6'b000011;
    localparam logic [5:0] RAW_BEQ = 6'b000100;
    localparam logic [5:0] RAW_BNE = 6'b000101;

endpackage

`default_nettype wire

// ==== pc_unit.sv ====
`default_nettype none

module pc_unit
    import mips_isa_pkg::*, fetch_if_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        accept_pulse,
    input  logic        redirect_valid,
    input  redirect_t   redirect,
    output logic [31:0] pc
);

    typedef enum logic {
        pc_run,     // stepping by 4
        pc_hold     // target waits for the delay slot read
    } pc_state_t;

    pc_state_t   state;
    logic [31:0] pc_q;
    logic [31:0] target_q;

    assign pc = pc_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc_q  <= BOOT_VECTOR;
            state <= pc_run;
        end else if (redirect_valid) begin
            if (pc_q == redirect.slot_pc && !accept_pulse) begin
                state <= pc_hold;                 // slot not read yet
            end else begin
                pc_q  <= redirect.target;         // slot already issued
                state <= pc_run;
            end
        end else if (state == pc_hold && accept_pulse) begin
            pc_q  <= target_q;                    // delay slot read accepted
            state <= pc_run;
        end else if (accept_pulse) begin
            pc_q <= pc_q + 32'd4;
        end
    end

    // pending branch register
    always_ff @(posedge clk) begin
        if (redirect_valid) begin
            target_q <= redirect.target;
        end
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
mips_isa_pkg.sv
fetch_if_pkg.sv
pc_unit.sv
fetch_stage.sv
branch_decode.sv
fetch_front_end.sv
fetch_front_end_assert.sv
fetch_front_end_tb.sv
